/* filelist.f */
rename_pkg.sv
free_list.sv
retire_map.sv
rename_map_table.sv
rename_unit.sv
tb_rename_unit.sv

/* free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input  logic clock,
	input  logic reset,
	input  logic [rename_pkg::n_way-1:0] alloc_request,
	input  logic [rename_pkg::n_way-1:0] release_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] release_tag,
	input  logic [rename_pkg::n_way-1:0] retire_advance,
	input  logic flush,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] alloc_tag,
	output logic [rename_pkg::count_bits-1:0] free_avail
);

	logic [rename_pkg::tag_bits-1:0] ring [rename_pkg::free_count];

	// head is the next tag to hand out, retire_head the oldest one still in flight.
	logic [rename_pkg::ptr_bits-1:0] head;
	logic [rename_pkg::ptr_bits-1:0] tail;
	logic [rename_pkg::ptr_bits-1:0] retire_head;
	logic [rename_pkg::count_bits-1:0] count;

	logic [rename_pkg::ptr_bits-1:0] head_next;
	logic [rename_pkg::ptr_bits-1:0] tail_next;
	logic [rename_pkg::ptr_bits-1:0] retire_next;
	logic [rename_pkg::count_bits-1:0] count_next;
	logic [rename_pkg::ptr_bits-1:0] write_ptr [rename_pkg::n_way];
	logic [rename_pkg::ptr_bits-1:0] read_ptr;

	// --------------------------------------------------
	// allocation window
	// --------------------------------------------------

	// the next n_way tags are always on offer; the top level packs them.
	always_comb begin
		read_ptr = head;
		for (int i = 0; i < rename_pkg::n_way; i++) begin
			alloc_tag[i] = ring[read_ptr];
			read_ptr = read_ptr + 1'b1;
		end
	end

	assign free_avail = count;

	// --------------------------------------------------
	// pointer update
	// --------------------------------------------------

	always_comb begin
		head_next = head;
		tail_next = tail;
		retire_next = retire_head;
		count_next = count;
		for (int i = 0; i < rename_pkg::n_way; i++) begin
			write_ptr[i] = tail_next;
			if (alloc_request[i]) begin
				head_next = head_next + 1'b1;
				count_next = count_next - 1'b1;
			end
			if (release_valid[i]) begin
				tail_next = tail_next + 1'b1;
				count_next = count_next + 1'b1;
			end
			if (retire_advance[i])
				retire_next = retire_next + 1'b1;
		end

		// in-flight and free tags together always fill the ring, so with nothing
		// in flight after the rewind every slot is free again.
		if (flush) begin
			head_next = retire_next;
			count_next = rename_pkg::free_count[rename_pkg::count_bits-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			retire_head <= '0;
			count <= rename_pkg::free_count[rename_pkg::count_bits-1:0];
			for (int i = 0; i < rename_pkg::free_count; i++)
				ring[i] <= rename_pkg::tag_bits'(rename_pkg::first_free_tag + i);
		end else begin
			head <= head_next;
			tail <= tail_next;
			retire_head <= retire_next;
			count <= count_next;
			for (int i = 0; i < rename_pkg::n_way; i++) begin
				if (release_valid[i])
					ring[write_ptr[i]] <= release_tag[i];
			end
		end
	end

endmodule

`default_nettype wire

/* rename_golden.mem */
// test dispatch_valid lane_valid, then per lane src1 src2 dest, then complete_valid tag0 tag1,
// retire_valid and per lane dest tag old_tag, flush, expected dispatch_ready,
// then per lane src1_tag src2_tag dest_tag old_tag, then src1_ready and src2_ready bits.
// test 1: identity mapping after reset, first tags 20 and 21.
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 00 00 00 00 00 00 00 00 00 00
01 01 03 01 02 03 04 05 06 00 00 00 00 00 00 00 00 00 00 00 01 01 02 20 03 04 05 21 06 03 03
// test 2: lane 1 reads and rewrites lane 0's dest, dest 0, an invalid lane.
02 01 03 03 07 08 08 06 08 00 00 00 00 00 00 00 00 00 00 00 01 20 07 22 08 22 21 23 22 00 01
02 01 03 08 00 00 00 03 09 00 00 00 00 00 00 00 00 00 00 00 01 23 00 00 00 00 20 24 09 02 01
02 01 01 09 01 0A 0A 00 0B 00 00 00 00 00 00 00 00 00 00 00 01 24 01 25 0A 25 00 00 0B 00 03
// test 3: tag 20 completes, then tag 27 completes, then both read from the table.
03 01 03 03 06 0B 0B 03 0C 01 20 00 00 00 00 00 00 00 00 00 01 20 21 26 0B 26 20 27 0C 01 02
03 01 03 03 0C 0D 06 0D 0E 02 00 27 00 00 00 00 00 00 00 00 01 20 27 28 0D 21 28 29 0E 01 01
03 01 01 0C 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 27 20 00 00 00 00 00 00 03 03
// test 4: eleven groups use up the free list.
04 01 03 00 0F 0F 0F 10 10 00 00 00 00 00 00 00 00 00 00 00 01 00 0F 2A 0F 2A 10 2B 10 01 03
04 01 03 00 11 11 11 12 12 00 00 00 00 00 00 00 00 00 00 00 01 00 11 2C 11 2C 12 2D 12 01 03
04 01 03 00 13 13 13 14 14 00 00 00 00 00 00 00 00 00 00 00 01 00 13 2E 13 2E 14 2F 14 01 03
04 01 03 00 15 15 15 16 16 00 00 00 00 00 00 00 00 00 00 00 01 00 15 30 15 30 16 31 16 01 03
04 01 03 00 17 17 17 18 18 00 00 00 00 00 00 00 00 00 00 00 01 00 17 32 17 32 18 33 18 01 03
04 01 03 00 19 19 19 1A 1A 00 00 00 00 00 00 00 00 00 00 00 01 00 19 34 19 34 1A 35 1A 01 03
04 01 03 00 1B 1B 1B 1C 1C 00 00 00 00 00 00 00 00 00 00 00 01 00 1B 36 1B 36 1C 37 1C 01 03
04 01 03 00 1D 1D 1D 1E 1E 00 00 00 00 00 00 00 00 00 00 00 01 00 1D 38 1D 38 1E 39 1E 01 03
04 01 03 00 1F 1F 1F 01 01 00 00 00 00 00 00 00 00 00 00 00 01 00 1F 3A 1F 3A 01 3B 01 01 03
04 01 03 00 02 02 02 04 04 00 00 00 00 00 00 00 00 00 00 00 01 00 02 3C 02 3C 04 3D 04 01 03
04 01 03 00 05 05 05 07 07 00 00 00 00 00 00 00 00 00 00 00 01 00 05 3E 05 3E 07 3F 07 01 03
// the held group waits until two retirements return tags 03 and 06.
04 01 03 01 02 03 03 06 06 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
04 01 03 01 02 03 03 06 06 00 00 00 03 03 20 03 06 21 06 00 00 00 00 00 00 00 00 00 00 00 00
04 01 03 01 02 03 03 06 06 00 00 00 00 00 00 00 00 00 00 00 01 3B 3C 03 20 03 21 06 21 00 00
// test 5: retire up to tag 24, flush in the same cycle as the last retirement.
05 00 00 00 00 00 00 00 00 00 00 00 03 08 22 08 08 23 22 00 00 00 00 00 00 00 00 00 00 00 00
05 01 03 01 02 03 03 06 06 00 00 00 01 09 24 09 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00
05 01 03 03 06 08 09 01 0B 00 00 00 00 00 00 00 00 00 00 00 01 20 21 25 23 24 01 26 0B 03 03
05 01 03 0C 0D 00 1F 08 01 00 00 00 00 00 00 00 00 00 00 00 01 0C 0D 00 00 1F 25 27 01 03 01

/* rename_map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_map_table (
	input  logic clock,
	input  logic reset,
	input  logic fire,
	input  logic [rename_pkg::n_way-1:0] lane_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src1,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src2,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] dest,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] new_tag,
	input  logic [rename_pkg::n_way-1:0] complete_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] complete_tag,
	input  logic flush,
	input  logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] arch_map,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src1_tag,
	output logic [rename_pkg::n_way-1:0] src1_ready,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src2_tag,
	output logic [rename_pkg::n_way-1:0] src2_ready,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] old_tag
);

	logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] map_tag;
	logic [rename_pkg::arch_regs-1:0] map_ready;

	logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] next_tag;
	logic [rename_pkg::arch_regs-1:0] next_ready;

	// true when some lane broadcasts this tag as complete in the current cycle.
	function automatic logic tag_waking(input logic [rename_pkg::tag_bits-1:0] tag);
		logic hit;
		hit = 1'b0;
		for (int c = 0; c < rename_pkg::n_way; c++) begin
			if (complete_valid[c] && complete_tag[c] == tag)
				hit = 1'b1;
		end
		return hit;
	endfunction

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------

	always_comb begin
		for (int l = 0; l < rename_pkg::n_way; l++) begin
			src1_tag[l] = map_tag[src1[l]];
			src2_tag[l] = map_tag[src2[l]];
			old_tag[l] = map_tag[dest[l]];
			src1_ready[l] = map_ready[src1[l]] || tag_waking(map_tag[src1[l]]);
			src2_ready[l] = map_ready[src2[l]] || tag_waking(map_tag[src2[l]]);

			// earlier lanes in the group override the table.
			// The nearest earlier writer wins because k counts upward.
			for (int k = 0; k < l; k++) begin
				if (lane_valid[k] && dest[k] != '0) begin
					if (dest[k] == src1[l]) begin
						src1_tag[l] = new_tag[k];
						src1_ready[l] = 1'b0;
					end
					if (dest[k] == src2[l]) begin
						src2_tag[l] = new_tag[k];
						src2_ready[l] = 1'b0;
					end
					if (dest[k] == dest[l])
						old_tag[l] = new_tag[k];
				end
			end
		end
	end

	// --------------------------------------------------
	// update
	// --------------------------------------------------

	always_comb begin
		next_tag = map_tag;
		next_ready = map_ready;

		if (flush) begin
			next_tag = arch_map;
			next_ready = '1;
		end

		// lanes go in order, so of two lanes with the same dest the later one stays.
		if (fire) begin
			for (int l = 0; l < rename_pkg::n_way; l++) begin
				if (lane_valid[l] && dest[l] != '0) begin
					next_tag[dest[l]] = new_tag[l];
					next_ready[dest[l]] = 1'b0;
				end
			end
		end

		// wakeup looks at the new mapping, so an entry that was just renamed
		// is not woken by the completion of its previous tag.
		for (int e = 0; e < rename_pkg::arch_regs; e++) begin
			if (tag_waking(next_tag[e]))
				next_ready[e] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_pkg::arch_regs; i++)
				map_tag[i] <= rename_pkg::tag_bits'(i);
			map_ready <= '1;
		end else begin
			map_tag <= next_tag;
			map_ready <= next_ready;
		end
	end

endmodule

`default_nettype wire

/* rename_pkg.sv */
`default_nettype none

package rename_pkg;

	// --------------------------------------------------
	// dispatch group
	// --------------------------------------------------

	// instructions renamed together in one cycle.
	localparam int n_way = 2;

	// --------------------------------------------------
	// register files
	// --------------------------------------------------

	localparam int arch_regs = 32;
	localparam int arch_bits = 5;

	localparam int phys_regs = 64;
	localparam int tag_bits = 6;

	// --------------------------------------------------
	// free list
	// --------------------------------------------------

	// once every architectural register holds a tag, the rest are free.
	localparam int free_count = phys_regs - arch_regs;

	// occupancy runs from 0 to free_count inclusive.
	localparam int count_bits = 6;

	// the ring has free_count slots, so its pointers wrap on their own.
	localparam int ptr_bits = 5;

	// reset mapping is identity, the free tags start right after it.
	localparam int first_free_tag = arch_regs;

endpackage

`default_nettype wire

/* rename_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
	input  logic clock,
	input  logic reset,

	input  logic dispatch_valid,
	output logic dispatch_ready,
	input  logic [rename_pkg::n_way-1:0] lane_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src1,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src2,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] dest,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src1_tag,
	output logic [rename_pkg::n_way-1:0] src1_ready,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src2_tag,
	output logic [rename_pkg::n_way-1:0] src2_ready,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] dest_tag,
	output logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] old_tag,

	input  logic [rename_pkg::n_way-1:0] complete_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] complete_tag,

	input  logic [rename_pkg::n_way-1:0] retire_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] retire_dest,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] retire_tag,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] retire_old_tag,

	input  logic flush
);

	logic active;
	logic fire;
	logic [rename_pkg::n_way-1:0] alloc_request;
	logic [rename_pkg::n_way-1:0] retire_alloc;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] alloc_tag;
	logic [rename_pkg::count_bits-1:0] free_avail;
	logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] arch_map;

	// dispatch opens the cycle after reset is released.
	always_ff @(posedge clock) begin
		if (reset)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	assign dispatch_ready = active && !flush &&
		(free_avail >= rename_pkg::count_bits'(rename_pkg::n_way));
	assign fire = dispatch_valid && dispatch_ready;

	// --------------------------------------------------
	// allocation and release
	// --------------------------------------------------

	always_comb begin
		for (int l = 0; l < rename_pkg::n_way; l++) begin
			alloc_request[l] = fire && lane_valid[l] && dest[l] != '0;
			retire_alloc[l] = retire_valid[l] && retire_dest[l] != '0;
		end
	end

	// allocating lanes take tags from the head in lane order.
	always_comb begin
		int slot;
		slot = 0;
		for (int l = 0; l < rename_pkg::n_way; l++) begin
			dest_tag[l] = '0;
			if (alloc_request[l]) begin
				dest_tag[l] = alloc_tag[slot];
				slot = slot + 1;
			end
		end
	end

	free_list free_list (
		.clock          (clock),
		.reset          (reset),
		.alloc_request  (alloc_request),
		.release_valid  (retire_alloc),
		.release_tag    (retire_old_tag),
		.retire_advance (retire_alloc),
		.flush          (flush),
		.alloc_tag      (alloc_tag),
		.free_avail     (free_avail)
	);

	retire_map retire_map (
		.clock        (clock),
		.reset        (reset),
		.retire_valid (retire_valid),
		.retire_dest  (retire_dest),
		.retire_tag   (retire_tag),
		.arch_map     (arch_map)
	);

	rename_map_table rename_map_table (
		.clock          (clock),
		.reset          (reset),
		.fire           (fire),
		.lane_valid     (lane_valid),
		.src1           (src1),
		.src2           (src2),
		.dest           (dest),
		.new_tag        (dest_tag),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.flush          (flush),
		.arch_map       (arch_map),
		.src1_tag       (src1_tag),
		.src1_ready     (src1_ready),
		.src2_tag       (src2_tag),
		.src2_ready     (src2_ready),
		.old_tag        (old_tag)
	);

endmodule

`default_nettype wire

/* retire_map.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_map (
	input  logic clock,
	input  logic reset,
	input  logic [rename_pkg::n_way-1:0] retire_valid,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] retire_dest,
	input  logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] retire_tag,
	output logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] arch_map
);

	logic [rename_pkg::arch_regs-1:0][rename_pkg::tag_bits-1:0] committed;

	// --------------------------------------------------
	// commit
	// --------------------------------------------------

	// arch_map already carries this cycle's retirements.
	// A flush in the same cycle therefore restores the fully updated mapping.
	always_comb begin
		arch_map = committed;
		for (int i = 0; i < rename_pkg::n_way; i++) begin
			// later lanes overwrite earlier ones, which keeps program order.
			if (retire_valid[i] && retire_dest[i] != '0)
				arch_map[retire_dest[i]] = retire_tag[i];
		end
	end

	// register 0 is never written, so it keeps tag 0 from reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_pkg::arch_regs; i++)
				committed[i] <= rename_pkg::tag_bits'(i);
		end else begin
			committed <= arch_map;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the rename stage testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rename_unit \
	-f filelist.f -o sim_rename_unit

# the exit status of the pipeline is that of tee, the log decides the result.
./obj_dir/sim_rename_unit 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

/* tb_rename_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

	localparam int clock_period = 8;
	localparam int reset_cycles = 16;
	localparam int num_vectors = 26;
	localparam int num_fields = 31;
	localparam int timeout_margin = 200;

	// column positions within one golden line.
	localparam int col_test = 0;
	localparam int col_dispatch = 1;
	localparam int col_lane_valid = 2;
	localparam int col_lane = 3;
	localparam int col_complete = 9;
	localparam int col_retire = 12;
	localparam int col_retire_lane = 13;
	localparam int col_flush = 19;
	localparam int col_ready = 20;
	localparam int col_expect_lane = 21;
	localparam int col_src1_ready = 29;
	localparam int col_src2_ready = 30;

	logic clock;
	logic reset;
	logic dispatch_valid;
	logic dispatch_ready;
	logic [rename_pkg::n_way-1:0] lane_valid;
	logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src1;
	logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] src2;
	logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] dest;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src1_tag;
	logic [rename_pkg::n_way-1:0] src1_ready;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] src2_tag;
	logic [rename_pkg::n_way-1:0] src2_ready;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] dest_tag;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] old_tag;
	logic [rename_pkg::n_way-1:0] complete_valid;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] complete_tag;
	logic [rename_pkg::n_way-1:0] retire_valid;
	logic [rename_pkg::n_way-1:0][rename_pkg::arch_bits-1:0] retire_dest;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] retire_tag;
	logic [rename_pkg::n_way-1:0][rename_pkg::tag_bits-1:0] retire_old_tag;
	logic flush;

	logic [7:0] golden [num_vectors * num_fields];
	string current_test;

	rename_unit uut (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.lane_valid     (lane_valid),
		.src1           (src1),
		.src2           (src2),
		.dest           (dest),
		.src1_tag       (src1_tag),
		.src1_ready     (src1_ready),
		.src2_tag       (src2_tag),
		.src2_ready     (src2_ready),
		.dest_tag       (dest_tag),
		.old_tag        (old_tag),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.retire_valid   (retire_valid),
		.retire_dest    (retire_dest),
		.retire_tag     (retire_tag),
		.retire_old_tag (retire_old_tag),
		.flush          (flush)
	);

	always #(clock_period / 2) clock = ~clock;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	function automatic string test_label(input logic [7:0] id);
		case (id)
			8'h01: return "reset_mapping";
			8'h02: return "group_bypass";
			8'h03: return "completion_wakeup";
			8'h04: return "back_pressure";
			8'h05: return "flush_recovery";
			default: return "unknown";
		endcase
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			stop_with_failure($sformatf("mismatch %s %s expected %02h actual %02h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic apply_vector(input int v);
		int base;
		base = v * num_fields;
		assert (golden[base + col_test] inside {[8'h01:8'h05]}) else begin
			stop_with_failure($sformatf(
				"golden line %0d has no known test number, the vector file may be missing", v));
		end
		current_test = test_label(golden[base + col_test]);
		dispatch_valid = golden[base + col_dispatch][0];
		lane_valid = golden[base + col_lane_valid][rename_pkg::n_way-1:0];
		complete_valid = golden[base + col_complete][rename_pkg::n_way-1:0];
		retire_valid = golden[base + col_retire][rename_pkg::n_way-1:0];
		flush = golden[base + col_flush][0];
		for (int l = 0; l < rename_pkg::n_way; l++) begin
			src1[l] = golden[base + col_lane + 3 * l][rename_pkg::arch_bits-1:0];
			src2[l] = golden[base + col_lane + 3 * l + 1][rename_pkg::arch_bits-1:0];
			dest[l] = golden[base + col_lane + 3 * l + 2][rename_pkg::arch_bits-1:0];
			complete_tag[l] = golden[base + col_complete + 1 + l][rename_pkg::tag_bits-1:0];
			retire_dest[l] = golden[base + col_retire_lane + 3 * l][rename_pkg::arch_bits-1:0];
			retire_tag[l] = golden[base + col_retire_lane + 3 * l + 1][rename_pkg::tag_bits-1:0];
			retire_old_tag[l] =
				golden[base + col_retire_lane + 3 * l + 2][rename_pkg::tag_bits-1:0];
		end
	endtask

	// rename outputs only mean something in a cycle where the group is accepted.
	task automatic check_outputs(input int v);
		int base;
		int at;
		base = v * num_fields;
		check_value("dispatch_ready", golden[base + col_ready], 8'(dispatch_ready));
		if (golden[base + col_dispatch][0] && golden[base + col_ready][0]) begin
			for (int l = 0; l < rename_pkg::n_way; l++) begin
				at = base + col_expect_lane + 4 * l;
				check_value($sformatf("src1_tag[%0d]", l), golden[at], 8'(src1_tag[l]));
				check_value($sformatf("src2_tag[%0d]", l), golden[at + 1], 8'(src2_tag[l]));
				check_value($sformatf("dest_tag[%0d]", l), golden[at + 2], 8'(dest_tag[l]));
				check_value($sformatf("old_tag[%0d]", l), golden[at + 3], 8'(old_tag[l]));
			end
			check_value("src1_ready", golden[base + col_src1_ready], 8'(src1_ready));
			check_value("src2_ready", golden[base + col_src2_ready], 8'(src2_ready));
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		lane_valid = '0;
		src1 = '0;
		src2 = '0;
		dest = '0;
		complete_valid = '0;
		complete_tag = '0;
		retire_valid = '0;
		retire_dest = '0;
		retire_tag = '0;
		retire_old_tag = '0;
		flush = 1'b0;
		current_test = "reset";
		$readmemh("rename_golden.mem", golden);

		repeat (reset_cycles) begin
			@(negedge clock);
			check_value("dispatch_ready", 8'h00, 8'(dispatch_ready));
		end
		reset = 1'b0;

		// inputs change on the falling edge and are checked halfway to the rising edge.
		for (int v = 0; v < num_vectors; v++) begin
			@(negedge clock);
			apply_vector(v);
			#(clock_period / 4);
			check_outputs(v);
		end
		@(negedge clock);

		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#((reset_cycles + num_vectors + 2) * clock_period + timeout_margin);
		$display("error: the run timed out before all golden vectors were applied");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
